//--- include/dbg_defs.svh
`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

//////////////////////////////////////////////////
// link sizing
//////////////////////////////////////////////////

// receive buffer depth in characters, also the host's starting credits
`define DBG_RX_DEPTH 4

// credits the printer holds after reset
`define DBG_TX_CREDITS 4

//////////////////////////////////////////////////
// target memory
//////////////////////////////////////////////////

// word index width, 256 words per memory
`define DBG_MEM_AW 8

//////////////////////////////////////////////////
// character codes
//////////////////////////////////////////////////

`define DBG_CH_NL 8'h0A
`define DBG_CH_SP 8'h20
`define DBG_CH_QM 8'h3F

`endif

//--- design/dbg_pkg.sv
`default_nettype none

package dbg_pkg;

    // token kinds from the scanner
    typedef enum logic [1:0]
    {
        TOK_CMD,
        TOK_HEX,
        TOK_END
    } tok_kind_e;

    // decoded command character
    typedef enum logic [2:0]
    {
        OP_DUMP_D,
        OP_DUMP_I,
        OP_WRITE_D,
        OP_WRITE_I,
        OP_BAD
    } cmd_op_e;

    // controller FSM states
    typedef enum logic [2:0]
    {
        ST_IDLE,
        ST_ARGS,
        ST_WRITE,
        ST_READ,
        ST_PRINT,
        ST_DRAIN
    } ctrl_state_e;

    // word answer or "?" answer
    typedef enum logic
    {
        PR_WORD,
        PR_QUERY
    } print_kind_e;

endpackage

`default_nettype wire

//--- design/char_scanner.sv
`timescale 1ns/100ps
`default_nettype none

`include "dbg_defs.svh"

module char_scanner
(
    input  wire logic             clk,
    input  wire logic             rstn,
    input  wire logic             rx_valid,
    input  wire logic [7:0]       rx_char,
    output logic                  rx_credit,
    output logic                  tok_valid,
    output dbg_pkg::tok_kind_e    tok_kind,
    output logic [31:0]           tok_value,
    input  wire logic             tok_ready
);

    localparam int DEPTH = `DBG_RX_DEPTH;
    localparam int PW    = $clog2(`DBG_RX_DEPTH);

    logic [7:0]    rx_buf [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   rx_count;

    logic          line_start;
    logic          num_pend;
    logic [31:0]   acc;

    logic [7:0]    head;
    logic [4:0]    head_hex;
    logic          slot_free;
    logic          pop;

    function automatic logic [PW-1:0] ptr_inc(input logic [PW-1:0] p);
        return (p == PW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // {valid, nibble} for one ascii character
    function automatic logic [4:0] hex_nib(input logic [7:0] c);
        logic [4:0] r;
        r = 5'h00;
        if (c >= "0" && c <= "9")
            r = {1'b1, 4'(c - "0")};
        else if (c >= "A" && c <= "F")
            r = {1'b1, 4'(c - "A" + 8'd10)};
        else if (c >= "a" && c <= "f")
            r = {1'b1, 4'(c - "a" + 8'd10)};
        return r;
    endfunction

    //////////////////////////////////////////////////
    // receive buffer
    //////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rx_valid)
            rx_buf[wr_ptr] <= rx_char;
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            rx_count <= '0;
        end
        else
        begin
            if (rx_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            rx_count <= rx_count + (PW+1)'(rx_valid) - (PW+1)'(pop);
        end
    end

    always_comb
    begin
        head      = rx_buf[rd_ptr];
        head_hex  = hex_nib(head);
        slot_free = !tok_valid || tok_ready;
        pop       = 1'b0;
        // a newline behind a pending number stays put for one more pass
        if (rx_count != '0 && slot_free)
            pop = !(head == `DBG_CH_NL && !line_start && num_pend);
    end

    //////////////////////////////////////////////////
    // tokenizer
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            tok_valid  <= 1'b0;
            tok_kind   <= dbg_pkg::TOK_CMD;
            tok_value  <= '0;
            line_start <= 1'b1;
            num_pend   <= 1'b0;
            acc        <= '0;
            rx_credit  <= 1'b0;
        end
        else
        begin
            rx_credit <= pop;
            if (tok_valid && tok_ready)
                tok_valid <= 1'b0;

            if (rx_count != '0 && slot_free)
            begin
                if (line_start)
                begin
                    // leading spaces and empty lines give nothing
                    if (head != `DBG_CH_NL && head != `DBG_CH_SP)
                    begin
                        tok_valid  <= 1'b1;
                        tok_kind   <= dbg_pkg::TOK_CMD;
                        tok_value  <= {24'h0, head};
                        line_start <= 1'b0;
                    end
                end
                else if (head == `DBG_CH_NL || head == `DBG_CH_SP)
                begin
                    if (num_pend)
                    begin
                        tok_valid <= 1'b1;
                        tok_kind  <= dbg_pkg::TOK_HEX;
                        tok_value <= acc;
                        num_pend  <= 1'b0;
                    end
                    else if (head == `DBG_CH_NL)
                    begin
                        tok_valid  <= 1'b1;
                        tok_kind   <= dbg_pkg::TOK_END;
                        tok_value  <= '0;
                        line_start <= 1'b1;
                    end
                end
                else if (head_hex[4])
                begin
                    // overlong numbers just shift out the top
                    acc      <= num_pend ? {acc[27:0], head_hex[3:0]} : {28'h0, head_hex[3:0]};
                    num_pend <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- design/dbg_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "dbg_defs.svh"

module dbg_ctrl
(
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic                  tok_valid,
    input  wire dbg_pkg::tok_kind_e    tok_kind,
    input  wire logic [31:0]           tok_value,
    output logic                       tok_ready,
    output logic [`DBG_MEM_AW-1:0]     mem_addr,
    output logic [31:0]                mem_wdata,
    output logic                       mem_sel_i,
    output logic                       mem_we,
    output logic                       mem_re,
    input  wire logic [31:0]           mem_rdata,
    output logic                       pr_start,
    output dbg_pkg::print_kind_e       pr_kind,
    output logic [31:0]                pr_word,
    input  wire logic                  pr_done
);

    dbg_pkg::ctrl_state_e state;
    dbg_pkg::cmd_op_e     op;
    logic [31:0]          arg0;
    logic [31:0]          arg1;
    logic [1:0]           argc;
    logic                 tok_fire;

    function automatic dbg_pkg::cmd_op_e decode(input logic [7:0] c);
        case (c)
            "D":     return dbg_pkg::OP_DUMP_D;
            "I":     return dbg_pkg::OP_DUMP_I;
            "W":     return dbg_pkg::OP_WRITE_D;
            "L":     return dbg_pkg::OP_WRITE_I;
            default: return dbg_pkg::OP_BAD;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // state decoded outputs
    //////////////////////////////////////////////////

    assign tok_ready = (state == dbg_pkg::ST_IDLE) || (state == dbg_pkg::ST_ARGS);
    assign tok_fire  = tok_valid && tok_ready;

    // first argument is the address, second the write value
    assign mem_addr  = arg0[`DBG_MEM_AW-1:0];
    assign mem_wdata = arg1;
    assign mem_sel_i = (op == dbg_pkg::OP_DUMP_I) || (op == dbg_pkg::OP_WRITE_I);
    assign mem_we    = state == dbg_pkg::ST_WRITE;
    assign mem_re    = state == dbg_pkg::ST_READ;

    // read data is already registered when ST_PRINT is reached
    assign pr_start = state == dbg_pkg::ST_PRINT;
    assign pr_kind  = (op == dbg_pkg::OP_BAD) ? dbg_pkg::PR_QUERY : dbg_pkg::PR_WORD;
    assign pr_word  = mem_rdata;

    //////////////////////////////////////////////////
    // command FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            state <= dbg_pkg::ST_IDLE;
            op    <= dbg_pkg::OP_BAD;
            arg0  <= '0;
            arg1  <= '0;
            argc  <= '0;
        end
        else
        begin
            case (state)
                dbg_pkg::ST_IDLE:
                begin
                    if (tok_fire && tok_kind == dbg_pkg::TOK_CMD)
                    begin
                        op    <= decode(tok_value[7:0]);
                        arg0  <= '0;
                        arg1  <= '0;
                        argc  <= '0;
                        state <= dbg_pkg::ST_ARGS;
                    end
                end
                dbg_pkg::ST_ARGS:
                begin
                    if (tok_fire && tok_kind == dbg_pkg::TOK_HEX)
                    begin
                        // anything past two arguments is dropped
                        if (argc == 2'd0)
                        begin
                            arg0 <= tok_value;
                            argc <= 2'd1;
                        end
                        else if (argc == 2'd1)
                        begin
                            arg1 <= tok_value;
                            argc <= 2'd2;
                        end
                    end
                    else if (tok_fire && tok_kind == dbg_pkg::TOK_END)
                    begin
                        case (op)
                            dbg_pkg::OP_WRITE_D,
                            dbg_pkg::OP_WRITE_I: state <= dbg_pkg::ST_WRITE;
                            dbg_pkg::OP_DUMP_D,
                            dbg_pkg::OP_DUMP_I:  state <= dbg_pkg::ST_READ;
                            default:             state <= dbg_pkg::ST_PRINT;
                        endcase
                    end
                end
                // write then read back the same word
                dbg_pkg::ST_WRITE: state <= dbg_pkg::ST_READ;
                dbg_pkg::ST_READ:  state <= dbg_pkg::ST_PRINT;
                dbg_pkg::ST_PRINT: state <= dbg_pkg::ST_DRAIN;
                dbg_pkg::ST_DRAIN:
                begin
                    // tokens stay blocked until the answer line is out
                    if (pr_done)
                        state <= dbg_pkg::ST_IDLE;
                end
                default: state <= dbg_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- design/hex_printer.sv
`timescale 1ns/100ps
`default_nettype none

`include "dbg_defs.svh"

module hex_printer
(
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic                  pr_start,
    input  wire dbg_pkg::print_kind_e  pr_kind,
    input  wire logic [31:0]           pr_word,
    output logic                       pr_done,
    output logic                       tx_valid,
    output logic [7:0]                 tx_char,
    input  wire logic                  tx_credit
);

    localparam int CW = $clog2(`DBG_TX_CREDITS + 1);

    logic [CW-1:0]        tx_cred;
    logic                 busy;
    // characters still to send, newline included
    logic [3:0]           left;
    logic [31:0]          sh;
    dbg_pkg::print_kind_e kind;

    //////////////////////////////////////////////////
    // character select
    //////////////////////////////////////////////////

    always_comb
    begin
        if (left == 4'd1)
            tx_char = `DBG_CH_NL;
        else if (kind == dbg_pkg::PR_QUERY)
            tx_char = `DBG_CH_QM;
        else if (sh[31:28] < 4'd10)
            tx_char = {4'h0, sh[31:28]} + 8'h30;
        else
            tx_char = {4'h0, sh[31:28]} + 8'h37;
    end

    // one character per cycle while a credit is held
    assign tx_valid = busy && (tx_cred != '0);

    //////////////////////////////////////////////////
    // credits and sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
            tx_cred <= CW'(`DBG_TX_CREDITS);
        else if (tx_credit && !tx_valid)
            tx_cred <= tx_cred + 1'b1;
        else if (!tx_credit && tx_valid)
            tx_cred <= tx_cred - 1'b1;
    end

    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            busy    <= 1'b0;
            left    <= '0;
            pr_done <= 1'b0;
        end
        else
        begin
            // done follows the newline by one cycle
            pr_done <= tx_valid && (left == 4'd1);
            if (pr_start)
            begin
                busy <= 1'b1;
                left <= (pr_kind == dbg_pkg::PR_QUERY) ? 4'd2 : 4'd9;
            end
            else if (tx_valid)
            begin
                left <= left - 1'b1;
                if (left == 4'd1)
                    busy <= 1'b0;
            end
        end
    end

    // nibble shifter, msb first
    always_ff @(posedge clk)
    begin
        if (pr_start)
        begin
            sh   <= pr_word;
            kind <= pr_kind;
        end
        else if (tx_valid)
            sh <= {sh[27:0], 4'h0};
    end

endmodule

`default_nettype wire

//--- design/target_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "dbg_defs.svh"

module target_mem
(
    input  wire logic                  clk,
    input  wire logic                  rstn,
    input  wire logic [`DBG_MEM_AW-1:0] mem_addr,
    input  wire logic [31:0]           mem_wdata,
    input  wire logic                  mem_sel_i,
    input  wire logic                  mem_we,
    input  wire logic                  mem_re,
    output logic [31:0]                mem_rdata
);

    localparam int WORDS = 1 << `DBG_MEM_AW;

    logic [31:0] imem [WORDS];
    logic [31:0] dmem [WORDS];

    // both arrays start out zeroed
    always_ff @(posedge clk or negedge rstn)
    begin
        if (!rstn)
        begin
            for (int i = 0; i < WORDS; i++)
            begin
                imem[i] <= '0;
                dmem[i] <= '0;
            end
        end
        else if (mem_we)
        begin
            if (mem_sel_i)
                imem[mem_addr] <= mem_wdata;
            else
                dmem[mem_addr] <= mem_wdata;
        end
    end

    // registered read, valid the cycle after mem_re
    always_ff @(posedge clk)
    begin
        if (mem_re)
            mem_rdata <= mem_sel_i ? imem[mem_addr] : dmem[mem_addr];
    end

endmodule

`default_nettype wire

//--- design/dbg_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "dbg_defs.svh"

module dbg_top
(
    input  wire logic        clk,
    input  wire logic        rstn,
    input  wire logic        rx_valid,
    input  wire logic [7:0]  rx_char,
    output logic             rx_credit,
    output logic             tx_valid,
    output logic [7:0]       tx_char,
    input  wire logic        tx_credit
);

    // scanner to controller
    logic                       tok_valid;
    dbg_pkg::tok_kind_e         tok_kind;
    logic [31:0]                tok_value;
    logic                       tok_ready;

    // controller to memory
    logic [`DBG_MEM_AW-1:0]     mem_addr;
    logic [31:0]                mem_wdata;
    logic                       mem_sel_i;
    logic                       mem_we;
    logic                       mem_re;
    logic [31:0]                mem_rdata;

    // controller to printer
    logic                       pr_start;
    dbg_pkg::print_kind_e       pr_kind;
    logic [31:0]                pr_word;
    logic                       pr_done;

    char_scanner u_scanner
    (
        .clk       (clk),
        .rstn      (rstn),
        .rx_valid  (rx_valid),
        .rx_char   (rx_char),
        .rx_credit (rx_credit),
        .tok_valid (tok_valid),
        .tok_kind  (tok_kind),
        .tok_value (tok_value),
        .tok_ready (tok_ready)
    );

    dbg_ctrl u_ctrl
    (
        .clk       (clk),
        .rstn      (rstn),
        .tok_valid (tok_valid),
        .tok_kind  (tok_kind),
        .tok_value (tok_value),
        .tok_ready (tok_ready),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_sel_i (mem_sel_i),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_rdata (mem_rdata),
        .pr_start  (pr_start),
        .pr_kind   (pr_kind),
        .pr_word   (pr_word),
        .pr_done   (pr_done)
    );

    hex_printer u_printer
    (
        .clk       (clk),
        .rstn      (rstn),
        .pr_start  (pr_start),
        .pr_kind   (pr_kind),
        .pr_word   (pr_word),
        .pr_done   (pr_done),
        .tx_valid  (tx_valid),
        .tx_char   (tx_char),
        .tx_credit (tx_credit)
    );

    target_mem u_mem
    (
        .clk       (clk),
        .rstn      (rstn),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_sel_i (mem_sel_i),
        .mem_we    (mem_we),
        .mem_re    (mem_re),
        .mem_rdata (mem_rdata)
    );

endmodule

`default_nettype wire

//--- tests/dbg_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module dbg_clk_gen
(
    output logic clk
);

    // 8 ns period
    localparam int HALF_NS = 4;

    initial
    begin
        clk = 1'b0;
        forever
            #HALF_NS clk = ~clk;
    end

endmodule

`default_nettype wire

//--- tests/dbg_chk.sv
`timescale 1ns/100ps
`default_nettype none

`include "dbg_defs.svh"

module dbg_chk
(
    input  wire logic                                     clk,
    input  wire logic                                     rstn,
    input  wire logic                                     rx_valid,
    input  wire logic [$clog2(`DBG_RX_DEPTH):0]           rx_count,
    input  wire logic                                     tx_valid,
    input  wire logic [$clog2(`DBG_TX_CREDITS + 1)-1:0]   tx_cred,
    input  wire logic                                     pr_busy,
    input  wire logic                                     pr_start,
    input  wire logic                                     mem_we,
    input  wire logic                                     mem_re,
    input  wire dbg_pkg::ctrl_state_e                     ctrl_state,
    input  wire logic                                     pr_done
);

    //////////////////////////////////////////////////
    // link credits and buffers
    //////////////////////////////////////////////////

    tx_needs_credit: assert property (@(posedge clk) disable iff (!rstn)
        tx_valid |-> tx_cred != '0)
        else $error("tx_valid high while the printer holds no credit");

    tx_cred_bound: assert property (@(posedge clk) disable iff (!rstn)
        tx_cred <= `DBG_TX_CREDITS)
        else $error("printer credit count above its reset value");

    // a full buffer means the host has no credit left
    rx_no_overflow: assert property (@(posedge clk) disable iff (!rstn)
        (rx_count < `DBG_RX_DEPTH) || ((rx_count == `DBG_RX_DEPTH) && !rx_valid))
        else $error("receive buffer overflow");

    //////////////////////////////////////////////////
    // controller side
    //////////////////////////////////////////////////

    mem_one_access: assert property (@(posedge clk) disable iff (!rstn)
        !(mem_we && mem_re))
        else $error("mem_we and mem_re high in the same cycle");

    start_when_idle: assert property (@(posedge clk) disable iff (!rstn)
        pr_start |-> !pr_busy)
        else $error("pr_start while the printer is busy");

    // the controller only waits while a line is still going out
    drain_waits_printer: assert property (@(posedge clk) disable iff (!rstn)
        (ctrl_state == dbg_pkg::ST_DRAIN) |-> (pr_busy || pr_done))
        else $error("controller waiting with the printer idle and no pr_done");

endmodule

`default_nettype wire

//--- tests/dbg_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "dbg_defs.svh"

module dbg_tb;

    localparam logic [31:0] SEED    = 32'h7d2eda60;
    localparam int          N_LINES = 200;
    localparam int          TIMEOUT = 20000;
    localparam int          WORDS   = 1 << `DBG_MEM_AW;

    logic       clk;
    logic       rstn;
    logic       rx_valid;
    logic [7:0] rx_char;
    logic       rx_credit;
    logic       tx_valid;
    logic [7:0] tx_char;
    logic       tx_credit;

    // host character stream, per character idle gaps, expected answers
    logic [7:0]  rx_q [$];
    int          gap_q [$];
    logic [7:0]  exp_q [$];
    logic [31:0] dmem_model [WORDS];
    logic [31:0] imem_model [WORDS];

    logic [31:0] seed;
    logic [31:0] gap_seed;
    int          next_stall;
    int          host_cred;
    int          tx_owed;
    int          n_checks;
    int          n_mismatch;
    int          n_other;
    bit          hung;

    dbg_clk_gen u_clk
    (
        .clk (clk)
    );

    dbg_top DUT
    (
        .clk       (clk),
        .rstn      (rstn),
        .rx_valid  (rx_valid),
        .rx_char   (rx_char),
        .rx_credit (rx_credit),
        .tx_valid  (tx_valid),
        .tx_char   (tx_char),
        .tx_credit (tx_credit)
    );

    bind dbg_top dbg_chk u_chk
    (
        .clk        (clk),
        .rstn       (rstn),
        .rx_valid   (rx_valid),
        .rx_count   (u_scanner.rx_count),
        .tx_valid   (tx_valid),
        .tx_cred    (u_printer.tx_cred),
        .pr_busy    (u_printer.busy),
        .pr_start   (pr_start),
        .mem_we     (mem_we),
        .mem_re     (mem_re),
        .ctrl_state (u_ctrl.state),
        .pr_done    (pr_done)
    );

    //////////////////////////////////////////////////
    // random numbers and helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // 0 .. n-1 from the stimulus stream
    function automatic int roll(input int n);
        seed = lcg_step(seed);
        return int'(seed[31:8] % n);
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] hi;
        hi = 32'(roll(65536));
        return {hi[15:0], 16'(roll(65536))};
    endfunction

    function automatic logic [7:0] hex_char(input logic [3:0] nib, input bit lower);
        if (nib < 4'd10)
            return 8'h30 + nib;
        return (lower ? 8'h61 : 8'h41) + nib - 8'd10;
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        n_checks++;
        if (got !== exp)
        begin
            n_mismatch++;
            $display("FAILED at %0d ns: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    //////////////////////////////////////////////////
    // command line builder with memory model
    //////////////////////////////////////////////////

    task automatic put_char(input logic [7:0] c);
        gap_q.push_back(next_stall + ((roll(8) == 0) ? 1 + roll(3) : 0));
        rx_q.push_back(c);
        next_stall = 0;
    endtask

    task automatic put_spaces(input int n);
        for (int i = 0; i < n; i++)
            put_char(`DBG_CH_SP);
    endtask

    // minimal digits, eight digits, or extra high digits that fall off
    task automatic put_number(input logic [31:0] v);
        int mode;
        int ndig;
        int extra;
        mode  = roll(3);
        ndig  = 8;
        extra = 0;
        if (mode == 0)
        begin
            while (ndig > 1 && (v >> ((ndig - 1) * 4)) == 0)
                ndig--;
        end
        else if (mode == 2)
            extra = 1 + roll(4);
        for (int i = 0; i < extra; i++)
            put_char(hex_char(4'(roll(16)), roll(2) == 1));
        for (int i = ndig - 1; i >= 0; i--)
            put_char(hex_char(4'(v >> (i * 4)), roll(2) == 1));
    endtask

    task automatic expect_word(input logic [31:0] w);
        for (int i = 7; i >= 0; i--)
            exp_q.push_back(hex_char(4'(w >> (i * 4)), 1'b0));
        exp_q.push_back(`DBG_CH_NL);
    endtask

    task automatic build_line();
        int          kind;
        int          nargs;
        int          r;
        logic [31:0] addr;
        logic [31:0] val;
        logic [7:0]  cmd;
        string       bad_cmds;
        bad_cmds   = "xd?Zqw";
        next_stall = (roll(12) == 0) ? 40 + roll(80) : 0;
        kind       = roll(20);
        addr       = (roll(4) == 0) ? rand_word() : 32'(roll(16));
        val        = rand_word();
        r          = roll(8);
        // empty line, maybe with spaces, gets no answer
        if (kind >= 18)
        begin
            put_spaces(roll(3));
            put_char(`DBG_CH_NL);
            return;
        end
        if (kind < 5)
            cmd = "W";
        else if (kind < 9)
            cmd = "D";
        else if (kind < 12)
            cmd = "L";
        else if (kind < 15)
            cmd = "I";
        else
            cmd = bad_cmds[roll(6)];
        if (cmd == "W" || cmd == "L")
            nargs = (r == 0) ? 0 : (r == 1) ? 1 : (r == 2) ? 3 : 2;
        else
            nargs = (r == 0) ? 0 : (r == 1) ? 2 : 1;
        // missing arguments count as zero
        if (nargs < 1)
            addr = '0;
        if (nargs < 2)
            val = '0;
        if (roll(4) == 0)
            put_spaces(1 + roll(2));
        put_char(cmd);
        for (int i = 0; i < nargs; i++)
        begin
            put_spaces(1 + roll(3));
            if (i == 0)
                put_number(addr);
            else if (i == 1)
                put_number(val);
            else
                put_number(rand_word());
        end
        put_spaces(roll(2));
        put_char(`DBG_CH_NL);
        case (cmd)
            "W":
            begin
                dmem_model[addr[`DBG_MEM_AW-1:0]] = val;
                expect_word(dmem_model[addr[`DBG_MEM_AW-1:0]]);
            end
            "L":
            begin
                imem_model[addr[`DBG_MEM_AW-1:0]] = val;
                expect_word(imem_model[addr[`DBG_MEM_AW-1:0]]);
            end
            "D": expect_word(dmem_model[addr[`DBG_MEM_AW-1:0]]);
            "I": expect_word(imem_model[addr[`DBG_MEM_AW-1:0]]);
            default:
            begin
                exp_q.push_back(`DBG_CH_QM);
                exp_q.push_back(`DBG_CH_NL);
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // host side of both links
    //////////////////////////////////////////////////

    task automatic send_all();
        int         waited;
        int         gap;
        logic [7:0] c;
        while (rx_q.size() > 0 && !hung)
        begin
            c   = rx_q.pop_front();
            gap = gap_q.pop_front();
            for (int i = 0; i < gap; i++)
            begin
                @(posedge clk);
                #1;
            end
            waited = 0;
            while (host_cred == 0 && !hung)
            begin
                @(posedge clk);
                #1;
                waited++;
                if (waited > TIMEOUT)
                begin
                    $display("timeout: no receive credit came back in %0d cycles", TIMEOUT);
                    n_other++;
                    hung = 1'b1;
                end
            end
            if (!hung)
            begin
                rx_valid = 1'b1;
                rx_char  = c;
                host_cred--;
                @(posedge clk);
                #1;
                rx_valid = 1'b0;
            end
        end
    endtask

    task automatic receive_all();
        int         waited;
        logic [7:0] want;
        while (exp_q.size() > 0 && !hung)
        begin
            want   = exp_q.pop_front();
            waited = 0;
            @(negedge clk);
            while (!tx_valid && !hung)
            begin
                waited++;
                if (waited > TIMEOUT)
                begin
                    $display("timeout: answer character %0d never came from the DUT", n_checks);
                    n_other++;
                    hung = 1'b1;
                end
                else
                    @(negedge clk);
            end
            if (!hung)
            begin
                check_value(tx_char, want, $sformatf("answer character %0d", n_checks));
                tx_owed++;
            end
        end
    endtask

    // nothing more may come out once all answers are in
    task automatic drain_check();
        for (int i = 0; i < 200; i++)
        begin
            @(negedge clk);
            if (tx_valid)
            begin
                $display("unexpected character %h from the DUT after the last answer", tx_char);
                n_other++;
                tx_owed++;
            end
        end
        check_value(host_cred, `DBG_RX_DEPTH, "receive credits held after the run");
    endtask

    always @(negedge clk)
    begin
        if (rstn && rx_credit)
        begin
            host_cred++;
            if (host_cred > `DBG_RX_DEPTH)
            begin
                $display("receive credits returned beyond the buffer depth, host holds %0d",
                         host_cred);
                n_other++;
            end
        end
    end

    // tx credits go back after random gaps, with an occasional long stall
    initial
    begin
        int gap;
        tx_credit = 1'b0;
        gap       = 0;
        gap_seed  = SEED;
        forever
        begin
            @(posedge clk);
            #1;
            tx_credit = 1'b0;
            if (gap > 0)
                gap--;
            else if (tx_owed > 0)
            begin
                tx_credit = 1'b1;
                tx_owed--;
                gap_seed = lcg_step(gap_seed);
                if (gap_seed[31:28] == 4'h0)
                    gap = 20 + int'(gap_seed[27:22]);
                else
                    gap = int'(gap_seed[27:26]);
            end
        end
    end

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial
    begin
        rstn       = 1'b0;
        rx_valid   = 1'b0;
        rx_char    = 8'h00;
        seed       = SEED;
        next_stall = 0;
        host_cred  = `DBG_RX_DEPTH;
        tx_owed    = 0;
        n_checks   = 0;
        n_mismatch = 0;
        n_other    = 0;
        hung       = 1'b0;
        for (int i = 0; i < WORDS; i++)
        begin
            dmem_model[i] = '0;
            imem_model[i] = '0;
        end
        for (int i = 0; i < N_LINES; i++)
            build_line();

        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;

        fork
            send_all();
            receive_all();
        join
        if (!hung)
            drain_check();

        $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- dbg_unit.f
+incdir+include
design/dbg_pkg.sv
design/char_scanner.sv
design/dbg_ctrl.sv
design/hex_printer.sv
design/target_mem.sv
design/dbg_top.sv
tests/dbg_clk_gen.sv
tests/dbg_chk.sv
tests/dbg_tb.sv

//--- Bender.yml
package:
  name: dbg_unit

sources:
  - include_dirs:
      - include
    files:
      - design/dbg_pkg.sv
      - design/char_scanner.sv
      - design/dbg_ctrl.sv
      - design/hex_printer.sv
      - design/target_mem.sv
      - design/dbg_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/dbg_clk_gen.sv
      - tests/dbg_chk.sv
      - tests/dbg_tb.sv
